/* filelist.f */
+incdir+logic
logic/vpu_isa_pkg.sv
logic/vpu_data_pkg.sv
logic/vpu_ifs.sv
logic/vpu_decode.sv
logic/vpu_execute.sv
logic/vpu_result.sv
logic/vpu_top.sv
tests/vpu_props.sv
tests/vpu_tb.sv

/* logic/vpu_data_pkg.sv */
`include "vpu_defs.svh"
`default_nettype none

package vpu_data_pkg;

	// Register number, shared by both files
	typedef logic [`VPU_ADDR_W-1:0] reg_addr_t;

	// One scalar, or one lane of a vector
	typedef logic [`VPU_SCALAR_W-1:0] scalar_t;

	// Lane 0 in bits 7..0, lane 15 in bits 127..120
	typedef logic [`VPU_VECTOR_W-1:0] vector_t;

endpackage

`default_nettype wire

/* logic/vpu_decode.sv */
`timescale 1ns/10ps
`include "vpu_defs.svh"
`default_nettype none

module vpu_decode
	import vpu_isa_pkg::*, vpu_data_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire instr_t instr,
	issue_if.producer iss,
	result_if.consumer wb
);

	logic instr_q_valid;
	instr_t instr_q;

	opcode_t f_op;
	reg_addr_t f_rd;
	reg_addr_t f_rs1;
	reg_addr_t f_rs2;
	imm_t f_imm;

	scalar_t sregs [`VPU_NREGS];
	vector_t vregs [`VPU_NREGS];

	logic s_we;
	logic v_we;
	scalar_t rd_a_s;
	scalar_t rd_b_s;
	vector_t rd_a_v;
	vector_t rd_b_v;

	////////////////////////////////////////////////////////////
	// Instruction latch
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_q_valid <= 1'b0;
		end else begin
			instr_q_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			instr_q <= instr;
		end
	end

	// Field split
	assign f_op = opcode_t'(instr_q[OPC_LSB +: OPC_W]);
	assign f_rd = instr_q[RD_LSB +: `VPU_ADDR_W];
	assign f_rs2 = instr_q[RS2_LSB +: `VPU_ADDR_W];
	assign f_rs1 = instr_q[RS1_LSB +: `VPU_ADDR_W];
	assign f_imm = instr_q[`VPU_SCALAR_W-1:0];

	////////////////////////////////////////////////////////////
	// Register files
	////////////////////////////////////////////////////////////
	assign s_we = wb.valid && !wb.is_vector;
	assign v_we = wb.valid && wb.is_vector;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `VPU_NREGS; i++) begin
				sregs[i] <= '0;
				vregs[i] <= '0;
			end
		end else begin
			if (s_we) begin
				sregs[wb.rd] <= wb.scalar_data;
			end
			if (v_we) begin
				vregs[wb.rd] <= wb.vector_data;
			end
		end
	end

	// Write-through: a write this cycle wins over the stored value
	assign rd_a_s = (s_we && wb.rd == f_rs1) ? wb.scalar_data : sregs[f_rs1];
	assign rd_b_s = (s_we && wb.rd == f_rs2) ? wb.scalar_data : sregs[f_rs2];
	assign rd_a_v = (v_we && wb.rd == f_rs1) ? wb.vector_data : vregs[f_rs1];
	assign rd_b_v = (v_we && wb.rd == f_rs2) ? wb.vector_data : vregs[f_rs2];

	////////////////////////////////////////////////////////////
	// Issue register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iss.valid <= 1'b0;
		end else begin
			iss.valid <= instr_q_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_q_valid) begin
			iss.op <= f_op;
			iss.rd <= f_rd;
			iss.rs1 <= f_rs1;
			iss.rs2 <= f_rs2;
			iss.a_scalar <= rd_a_s;
			// Immediate replaces source 2 for LI
			iss.b_scalar <= (f_op == OP_LI) ? f_imm : rd_b_s;
			iss.a_vector <= rd_a_v;
			iss.b_vector <= rd_b_v;
		end
	end

endmodule

`default_nettype wire

/* logic/vpu_defs.svh */
`ifndef VPU_DEFS_SVH
`define VPU_DEFS_SVH

`default_nettype none

// Scalar register width, also the width of one vector lane
`define VPU_SCALAR_W 8
`define VPU_LANES 16
`define VPU_VECTOR_W (`VPU_LANES * `VPU_SCALAR_W)

// Instruction word: opcode, rd, rs2, rs1
`define VPU_INSTR_W 20

// Register files, same depth for scalar and vector
`define VPU_NREGS 32
`define VPU_ADDR_W 5

`default_nettype wire

`endif

/* logic/vpu_execute.sv */
`timescale 1ns/10ps
`include "vpu_defs.svh"
`default_nettype none

module vpu_execute
	import vpu_isa_pkg::*, vpu_data_pkg::*;
(
	issue_if.consumer iss,
	result_if.consumer wb,
	result_if.producer ex_res
);

	logic fwd_a_s;
	logic fwd_b_s;
	logic fwd_a_v;
	logic fwd_b_v;
	scalar_t a_s;
	scalar_t b_s;
	vector_t a_v;
	vector_t b_v;

	scalar_t res_s;
	vector_t res_v;
	logic wr_s;
	logic wr_v;

	// One 8-bit operation, used by the scalar ALU and by every lane
	function automatic scalar_t lane_op(opcode_t op, scalar_t a, scalar_t b);
		logic [2*`VPU_SCALAR_W-1:0] rot;
		rot = {a, a} << b[2:0];
		case (op)
			OP_ADD, OP_VADD: lane_op = a + b;
			OP_SUB, OP_VSUB: lane_op = a - b;
			OP_XOR, OP_VXOR: lane_op = a ^ b;
			OP_AND, OP_VAND: lane_op = a & b;
			OP_ROL, OP_VROL: lane_op = rot[2*`VPU_SCALAR_W-1 -: `VPU_SCALAR_W];
			default: lane_op = a;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Forwarding from the result stage
	////////////////////////////////////////////////////////////
	assign fwd_a_s = wb.valid && !wb.is_vector && wb.rd == iss.rs1;
	// LI has no second source register
	assign fwd_b_s = wb.valid && !wb.is_vector && wb.rd == iss.rs2 && iss.op != OP_LI;
	assign fwd_a_v = wb.valid && wb.is_vector && wb.rd == iss.rs1;
	assign fwd_b_v = wb.valid && wb.is_vector && wb.rd == iss.rs2;

	assign a_s = fwd_a_s ? wb.scalar_data : iss.a_scalar;
	assign b_s = fwd_b_s ? wb.scalar_data : iss.b_scalar;
	assign a_v = fwd_a_v ? wb.vector_data : iss.a_vector;
	assign b_v = fwd_b_v ? wb.vector_data : iss.b_vector;

	////////////////////////////////////////////////////////////
	// Scalar and lane-wise ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		res_s = '0;
		res_v = '0;
		wr_s = 1'b0;
		wr_v = 1'b0;
		case (iss.op)
			OP_LI: begin
				wr_s = 1'b1;
				res_s = b_s;
			end
			OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_ROL: begin
				wr_s = 1'b1;
				res_s = lane_op(iss.op, a_s, b_s);
			end
			OP_VADD, OP_VSUB, OP_VXOR, OP_VAND, OP_VROL: begin
				wr_v = 1'b1;
				for (int l = 0; l < `VPU_LANES; l++) begin
					res_v[l*`VPU_SCALAR_W +: `VPU_SCALAR_W] =
						lane_op(iss.op, a_v[l*`VPU_SCALAR_W +: `VPU_SCALAR_W],
							b_v[l*`VPU_SCALAR_W +: `VPU_SCALAR_W]);
				end
			end
			OP_VSPLAT: begin
				wr_v = 1'b1;
				res_v = {`VPU_LANES{a_s}};
			end
			default: begin
				// NOP and unknown codes write nothing
				wr_s = 1'b0;
			end
		endcase
	end

	assign ex_res.valid = iss.valid && (wr_s || wr_v);
	assign ex_res.is_vector = iss.valid && wr_v;
	assign ex_res.rd = iss.rd;
	assign ex_res.scalar_data = res_s;
	assign ex_res.vector_data = res_v;

endmodule

`default_nettype wire

/* logic/vpu_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////
// Decode to execute, straight from the issue register
////////////////////////////////////////////////////////////
interface issue_if
	import vpu_isa_pkg::*, vpu_data_pkg::*;
();
	logic valid;
	opcode_t op;
	reg_addr_t rd;
	reg_addr_t rs1;
	reg_addr_t rs2;
	scalar_t a_scalar;
	// LI immediate rides here
	scalar_t b_scalar;
	vector_t a_vector;
	vector_t b_vector;

	modport producer (output valid, op, rd, rs1, rs2, a_scalar, b_scalar, a_vector, b_vector);
	modport consumer (input valid, op, rd, rs1, rs2, a_scalar, b_scalar, a_vector, b_vector);
endinterface

////////////////////////////////////////////////////////////
// Finished result, either from execute or from the result stage
////////////////////////////////////////////////////////////
interface result_if
	import vpu_data_pkg::*;
();
	logic valid;
	logic is_vector;
	reg_addr_t rd;
	scalar_t scalar_data;
	vector_t vector_data;

	modport producer (output valid, is_vector, rd, scalar_data, vector_data);
	modport consumer (input valid, is_vector, rd, scalar_data, vector_data);
endinterface

`default_nettype wire

/* logic/vpu_isa_pkg.sv */
`include "vpu_defs.svh"
`default_nettype none

package vpu_isa_pkg;

	// Fields, high to low: opcode 19..15, rd 14..10, rs2 9..5, rs1 4..0
	// LI takes its immediate from bits 7..0
	localparam int OPC_W = 5;
	localparam int OPC_LSB = 15;
	localparam int RD_LSB = 10;
	localparam int RS2_LSB = 5;
	localparam int RS1_LSB = 0;

	typedef logic [`VPU_INSTR_W-1:0] instr_t;
	typedef logic [`VPU_SCALAR_W-1:0] imm_t;

	// Vector codes sit 8 above their scalar twins
	typedef enum logic [OPC_W-1:0] {
		OP_NOP    = 5'd0,
		OP_LI     = 5'd1,
		OP_ADD    = 5'd2,
		OP_SUB    = 5'd3,
		OP_XOR    = 5'd4,
		OP_AND    = 5'd5,
		OP_ROL    = 5'd6,
		OP_VADD   = 5'd10,
		OP_VSUB   = 5'd11,
		OP_VXOR   = 5'd12,
		OP_VAND   = 5'd13,
		OP_VROL   = 5'd14,
		OP_VSPLAT = 5'd15
	} opcode_t;

endpackage

`default_nettype wire

/* logic/vpu_result.sv */
`timescale 1ns/10ps
`default_nettype none

module vpu_result (
	input wire logic clk,
	input wire logic rst_n,
	result_if.consumer ex_res,
	result_if.producer wb
);

	////////////////////////////////////////////////////////////
	// Result stage register
	////////////////////////////////////////////////////////////

	// Control half, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
			wb.is_vector <= 1'b0;
		end else begin
			wb.valid <= ex_res.valid;
			wb.is_vector <= ex_res.is_vector;
		end
	end

	// Payload, only taken for a real result
	always_ff @(posedge clk) begin
		if (ex_res.valid) begin
			wb.rd <= ex_res.rd;
			wb.scalar_data <= ex_res.scalar_data;
			wb.vector_data <= ex_res.vector_data;
		end
	end

endmodule

`default_nettype wire

/* logic/vpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module vpu_top
	import vpu_isa_pkg::*, vpu_data_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire instr_t instr,
	output logic wb_valid,
	output logic wb_vector,
	output reg_addr_t wb_rd,
	output scalar_t wb_scalar,
	output vector_t wb_vec_data
);

	issue_if iss ();
	result_if ex_res ();
	result_if wb ();

	////////////////////////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////////////////////////
	vpu_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.iss(iss.producer),
		.wb(wb.consumer)
	);

	vpu_execute u_execute (
		.iss(iss.consumer),
		.wb(wb.consumer),
		.ex_res(ex_res.producer)
	);

	vpu_result u_result (
		.clk(clk),
		.rst_n(rst_n),
		.ex_res(ex_res.consumer),
		.wb(wb.producer)
	);

	// Writeback seen from outside
	assign wb_valid = wb.valid;
	assign wb_vector = wb.is_vector;
	assign wb_rd = wb.rd;
	assign wb_scalar = wb.scalar_data;
	assign wb_vec_data = wb.vector_data;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module vpu_tb \
	-o vpu_sim; then
	echo "Build failed"
	exit 1
fi

if ! out=$(./obj_dir/vpu_sim); then
	echo "$out"
	echo "Simulation exited with an error"
	exit 1
fi

echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
	exit 0
else
	exit 1
fi

/* tests/vpu_props.sv */
`timescale 1ns/10ps
`include "vpu_defs.svh"
`default_nettype none

module vpu_props
	import vpu_isa_pkg::*, vpu_data_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic instr_valid,
	input wire instr_t instr,
	input wire logic wb_valid,
	input wire logic wb_vector
);

	// Opcodes that produce a register write
	function automatic logic writes_reg(logic [OPC_W-1:0] code);
		return (code >= 5'd1 && code <= 5'd6) || (code >= 5'd10 && code <= 5'd15);
	endfunction

	// Quiet writeback while in reset and right after it
	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
		else $error("wb_valid high during reset");
	a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
		else $error("wb_valid high just after reset");

	// Fixed three-cycle latency for writing instructions
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && writes_reg(instr[OPC_LSB +: OPC_W])) |-> ##3 wb_valid)
		else $error("writeback missing three cycles after a writing instruction");

	a_vector_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wb_vector |-> wb_valid)
		else $error("wb_vector high without wb_valid");

endmodule

`default_nettype wire

/* tests/vpu_tb.sv */
`timescale 1ns/10ps
`include "vpu_defs.svh"
`default_nettype none

bind vpu_top vpu_props u_props (
	.clk(clk),
	.rst_n(rst_n),
	.instr_valid(instr_valid),
	.instr(instr),
	.wb_valid(wb_valid),
	.wb_vector(wb_vector)
);

module vpu_tb
	import vpu_isa_pkg::*, vpu_data_pkg::*;
();

	localparam int MAX_CYCLES = 2000;

	logic clk;
	logic rst_n;
	logic instr_valid;
	instr_t instr;
	logic wb_valid;
	logic wb_vector;
	reg_addr_t wb_rd;
	scalar_t wb_scalar;
	vector_t wb_vec_data;

	int cycles;
	int neg_cyc;
	int err_count;
	int wb_count;

	// Reference register files
	scalar_t ref_s [`VPU_NREGS];
	vector_t ref_v [`VPU_NREGS];

	// Expected writebacks, oldest first
	int exp_tag [$];
	logic exp_vec [$];
	reg_addr_t exp_rd [$];
	scalar_t exp_s [$];
	vector_t exp_v [$];

	vpu_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_vector(wb_vector),
		.wb_rd(wb_rd),
		.wb_scalar(wb_scalar),
		.wb_vec_data(wb_vec_data)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic scalar_t rol8(scalar_t a, logic [2:0] n);
		return scalar_t'(a << n) | scalar_t'(a >> (4'd8 - {1'b0, n}));
	endfunction

	// Scalar rule by the low three bits of the code
	function automatic scalar_t calc8(logic [2:0] kind, scalar_t a, scalar_t b);
		case (kind)
			3'd2: return a + b;
			3'd3: return a - b;
			3'd4: return a ^ b;
			3'd5: return a & b;
			default: return rol8(a, b[2:0]);
		endcase
	endfunction

	function automatic instr_t enc(logic [4:0] op, reg_addr_t rd, reg_addr_t rs2, reg_addr_t rs1);
		return {op, rd, rs2, rs1};
	endfunction

	function automatic instr_t enc_li(reg_addr_t rd, scalar_t imm);
		return {OP_LI, rd, 2'b00, imm};
	endfunction

	task automatic model_apply(input instr_t w, input int tag);
		logic [4:0] op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		vector_t v;
		op = w[19:15];
		rd = w[14:10];
		rs2 = w[9:5];
		rs1 = w[4:0];
		v = '0;
		if (op == 5'd1 || (op >= 5'd2 && op <= 5'd6)) begin
			ref_s[rd] = (op == 5'd1) ? w[7:0] : calc8(op[2:0], ref_s[rs1], ref_s[rs2]);
			exp_tag.push_back(tag);
			exp_vec.push_back(1'b0);
			exp_rd.push_back(rd);
			exp_s.push_back(ref_s[rd]);
			exp_v.push_back('0);
		end else if (op >= 5'd10 && op <= 5'd15) begin
			for (int l = 0; l < `VPU_LANES; l++) begin
				if (op == 5'd15)
					v[l*8 +: 8] = ref_s[rs1];
				else
					v[l*8 +: 8] = calc8(op[2:0],
						ref_v[rs1][l*8 +: 8], ref_v[rs2][l*8 +: 8]);
			end
			ref_v[rd] = v;
			exp_tag.push_back(tag);
			exp_vec.push_back(1'b1);
			exp_rd.push_back(rd);
			exp_s.push_back('0);
			exp_v.push_back(v);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////
	task automatic send_instr(input instr_t w);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= w;
		// Taken one edge later, written back three edges after that
		model_apply(w, neg_cyc + 4);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			instr <= '0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_tag.size() != 0)
			@(posedge clk);
		idle(2);
	endtask

	////////////////////////////////////////////////////////////
	// Writeback checker, sampled mid-cycle
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		neg_cyc = neg_cyc + 1;
		while (exp_tag.size() != 0 && exp_tag[0] < neg_cyc) begin
			$display("Expected writeback to r%0d did not arrive (time %0t)", exp_rd[0], $time);
			err_count++;
			void'(exp_tag.pop_front());
			void'(exp_vec.pop_front());
			void'(exp_rd.pop_front());
			void'(exp_s.pop_front());
			void'(exp_v.pop_front());
		end
		if (rst_n && wb_valid) begin
			wb_count++;
			if (exp_tag.size() == 0 || exp_tag[0] != neg_cyc) begin
				$display("Unexpected writeback to r%0d at time %0t", wb_rd, $time);
				err_count++;
			end else begin
				if (wb_vector != exp_vec[0] || wb_rd != exp_rd[0]) begin
					$display("Error at %0t: target vec=%0b r%0d, expected vec=%0b r%0d",
						$time, wb_vector, wb_rd, exp_vec[0], exp_rd[0]);
					err_count++;
				end else if (!exp_vec[0] && wb_scalar != exp_s[0]) begin
					$display("Error at %0t: r%0d = %h, expected %h",
						$time, wb_rd, wb_scalar, exp_s[0]);
					err_count++;
				end else if (exp_vec[0] && wb_vec_data != exp_v[0]) begin
					$display("Error at %0t: v%0d = %h, expected %h",
						$time, wb_rd, wb_vec_data, exp_v[0]);
					err_count++;
				end
				void'(exp_tag.pop_front());
				void'(exp_vec.pop_front());
				void'(exp_rd.pop_front());
				void'(exp_s.pop_front());
				void'(exp_v.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_stays_quiet();
		repeat (8) begin
			@(negedge clk);
			if (wb_valid) begin
				$display("Error at %0t: wb_valid high with no instruction", $time);
				err_count++;
			end
		end
	endtask

	task automatic scalar_alu_ops();
		send_instr(enc_li(5'd1, 8'hC8));
		send_instr(enc_li(5'd2, 8'h5B));
		idle(3);
		send_instr(enc(OP_ADD, 5'd3, 5'd2, 5'd1));
		send_instr(enc(OP_SUB, 5'd4, 5'd1, 5'd2));
		send_instr(enc(OP_XOR, 5'd5, 5'd2, 5'd1));
		send_instr(enc(OP_AND, 5'd6, 5'd2, 5'd1));
		send_instr(enc(OP_ROL, 5'd7, 5'd2, 5'd1));
		send_instr(enc(OP_ROL, 5'd8, 5'd0, 5'd1));
		drain();
	endtask

	task automatic dependency_chains();
		// Distance 1, forwarded from the result stage
		send_instr(enc_li(5'd10, 8'h91));
		send_instr(enc(OP_ADD, 5'd11, 5'd10, 5'd10));
		send_instr(enc(OP_XOR, 5'd12, 5'd10, 5'd11));
		send_instr(enc(OP_ROL, 5'd12, 5'd11, 5'd12));
		// Distance 2, through register write-through
		send_instr(enc(OP_SUB, 5'd13, 5'd12, 5'd10));
		send_instr(enc_li(5'd20, 8'h07));
		send_instr(enc(OP_ADD, 5'd14, 5'd13, 5'd13));
		// Distance 3
		send_instr(enc_li(5'd21, 8'h33));
		send_instr(enc_li(5'd22, 8'h44));
		send_instr(enc(OP_AND, 5'd15, 5'd21, 5'd14));
		drain();
	endtask

	task automatic vector_lane_ops();
		send_instr(enc_li(5'd1, 8'hF0));
		send_instr(enc_li(5'd2, 8'h23));
		send_instr(enc(OP_VSPLAT, 5'd1, 5'd0, 5'd1));
		send_instr(enc(OP_VSPLAT, 5'd2, 5'd0, 5'd2));
		send_instr(enc(OP_VADD, 5'd3, 5'd2, 5'd1));
		send_instr(enc(OP_VSUB, 5'd4, 5'd1, 5'd3));
		send_instr(enc(OP_VXOR, 5'd5, 5'd4, 5'd3));
		send_instr(enc(OP_VAND, 5'd6, 5'd1, 5'd5));
		send_instr(enc(OP_VROL, 5'd7, 5'd2, 5'd6));
		send_instr(enc(OP_VROL, 5'd7, 5'd5, 5'd7));
		drain();
	endtask

	task automatic random_mix();
		logic [4:0] op;
		for (int i = 0; i < 300; i++) begin
			// Mostly known codes, some from the unused range
			op = ($urandom % 4 == 0) ? 5'($urandom % 32) : 5'($urandom % 16);
			send_instr(enc(op, 5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8)));
		end
		drain();
	endtask

	initial begin
		void'($urandom(7));
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		cycles = 0;
		neg_cyc = 0;
		err_count = 0;
		wb_count = 0;
		for (int i = 0; i < `VPU_NREGS; i++) begin
			ref_s[i] = '0;
			ref_v[i] = '0;
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		reset_stays_quiet();
		scalar_alu_ops();
		dependency_chains();
		vector_lane_ops();
		random_mix();
		$display("Summary: %0d writebacks seen, %0d errors", wb_count, err_count);
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
